// File: Makefile
VERILATOR ?= verilator
TOP       ?= qnt_tb
FLIST     ?= compile.f
BUILD     ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

sim: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD)

// File: compile.f
logic/qnt_pkg.sv
logic/qnt_ctrl.sv
logic/qnt_addr_gen.sv
logic/qnt_cmp_acc.sv
logic/qnt_top.sv
test/qnt_properties.sv
test/qnt_checker.sv
test/qnt_tb.sv

// File: logic/qnt_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module qnt_addr_gen
  import qnt_pkg::*;
#(
  parameter int unsigned TREE_STRIDE = 16 // entries from pixel 0 tree to pixel 1 tree
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load_i,
  input  qnt_cmd_t   cmd_i,
  input  logic       fetch_pixel_i,
  input  logic       step_en_i,
  input  logic [1:0] level_i,
  input  logic [1:0] greater_i,   // last decision per pixel, registered
  output thr_addr_t  addr_o
);

  logic [1:0][3:0] pos_q;       // per pixel node, 1-based, last one fetched
  logic      [3:0] root;        // 8 or 2 depending on mode
  logic      [3:0] step;        // halves per level
  logic      [3:0] node;        // node of the current fetch
  logic      [3:0] pos_sel;
  thr_addr_t       tree_base;

  assign root    = (cmd_i.mode == MODE_4BIT) ? 4'd8 : 4'd2;
  assign step    = root >> level_i; // 4,2,1 or 1 past level 0
  assign pos_sel = pos_q[fetch_pixel_i];

  // move from the previous node by the previous decision of this pixel
  always_comb begin
    if (level_i == 2'd0) begin
      node = pos_sel;                // root, no decision yet
    end else if (greater_i[fetch_pixel_i]) begin
      node = pos_sel + step;         // pixel above, go up the sorted list
    end else begin
      node = pos_sel - step;
    end
  end

  //////////////////////////////////////////////////
  // address
  //////////////////////////////////////////////////

  assign tree_base = fetch_pixel_i ? (cmd_i.base + thr_addr_t'(TREE_STRIDE)) : cmd_i.base;
  assign addr_o    = tree_base + thr_addr_t'(node) - thr_addr_t'(1); // node is 1-based

  //////////////////////////////////////////////////
  // node positions
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos_q <= '0;
    end else if (load_i) begin
      pos_q[0] <= (cmd_i.mode == MODE_4BIT) ? 4'd8 : 4'd2; // cmd_i not yet loaded here
      pos_q[1] <= (cmd_i.mode == MODE_4BIT) ? 4'd8 : 4'd2;
    end else if (step_en_i) begin
      pos_q[fetch_pixel_i] <= node; // keep node, decision lands in cmp_acc on this edge
    end
  end

endmodule

`default_nettype wire

// File: logic/qnt_cmp_acc.sv
`timescale 1ns/100ps
`default_nettype none

module qnt_cmp_acc
  import qnt_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        load_i,
  input  qnt_cmd_t    cmd_i,
  input  logic        fetch_pixel_i,
  input  logic        step_en_i,
  input  pixel_t      rdata_i,      // threshold from memory
  output logic [1:0]  greater_o,    // registered decision per pixel
  output qnt_result_t res_o
);

  logic [1:0]      greater_q;
  logic [1:0][3:0] acc_q;     // per pixel result, msb first
  pixel_t          pix_sel;
  logic            greater;

  //////////////////////////////////////////////////
  // compare
  //////////////////////////////////////////////////

  assign pix_sel = fetch_pixel_i ? cmd_i.pixel1 : cmd_i.pixel0;
  assign greater = (pix_sel > rdata_i); // both signed, equal counts as not greater

  //////////////////////////////////////////////////
  // decision + shift registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      greater_q <= '0;
      acc_q     <= '0;
    end else if (load_i) begin
      greater_q <= '0;
      acc_q     <= '0; // fresh count per command
    end else if (step_en_i) begin
      greater_q[fetch_pixel_i] <= greater;
      acc_q[fetch_pixel_i]     <= {acc_q[fetch_pixel_i][2:0], greater};
    end
  end

  assign greater_o = greater_q;

  //////////////////////////////////////////////////
  // result packing
  //////////////////////////////////////////////////

  // 2-bit mode only shifts twice, low bits hold the count
  always_comb begin
    if (cmd_i.mode == MODE_4BIT) begin
      res_o = {acc_q[1], acc_q[0]};
    end else begin
      res_o = {4'b0000, acc_q[1][1:0], acc_q[0][1:0]};
    end
  end

endmodule

`default_nettype wire

// File: logic/qnt_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module qnt_ctrl
  import qnt_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // command handshake
  input  logic       cmd_valid_i,
  output logic       cmd_ready_o,
  input  qnt_mode_e  mode_i,        // from the registered command

  // threshold memory handshake
  input  logic       thr_gnt_i,
  input  logic       thr_rvalid_i,
  output logic       thr_req_o,     // request strobe, addr comes from qnt_addr_gen

  // result handshake
  input  logic       res_ready_i,
  output logic       res_valid_o,

  // datapath control
  output logic       load_o,        // command accepted this edge
  output logic       fetch_pixel_o, // 0 = pixel 0, 1 = pixel 1
  output logic       step_en_o,     // threshold arrives, compare + shift
  output logic [1:0] level_o        // tree level of the current fetch
);

  qnt_state_e state_q, state_d;
  logic [1:0] level_q, level_d;
  logic       pend_q, pend_d;  // granted, rvalid still to come
  logic [1:0] last_level;      // final level for this mode
  logic       fetching;

  //////////////////////////////////////////////////
  // decoded outputs
  //////////////////////////////////////////////////

  assign last_level = (mode_i == MODE_4BIT) ? 2'd3 : 2'd1;
  assign fetching   = (state_q == FETCH_P0) || (state_q == FETCH_P1);

  assign cmd_ready_o   = (state_q == IDLE);
  assign load_o        = cmd_ready_o & cmd_valid_i;
  assign res_valid_o   = (state_q == DONE);

  // only one outstanding request, so req drops between grant and rvalid
  assign thr_req_o     = fetching & ~pend_q;
  assign step_en_o     = fetching & pend_q & thr_rvalid_i;
  assign fetch_pixel_o = (state_q == FETCH_P1);
  assign level_o       = level_q;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    level_d = level_q;
    pend_d  = pend_q;

    case (state_q)
      IDLE: begin
        if (load_o) begin
          state_d = FETCH_P0; // first request in the next cycle
          level_d = 2'd0;
          pend_d  = 1'b0;
        end
      end

      FETCH_P0: begin
        if (thr_req_o && thr_gnt_i) begin
          pend_d = 1'b1; // addr taken, wait for data
        end
        if (step_en_o) begin
          pend_d  = 1'b0;
          state_d = FETCH_P1; // same level, other pixel
        end
      end

      FETCH_P1: begin
        if (thr_req_o && thr_gnt_i) begin
          pend_d = 1'b1;
        end
        if (step_en_o) begin
          pend_d = 1'b0;
          if (level_q == last_level) begin
            state_d = DONE; // both trees walked to the leaf
          end else begin
            state_d = FETCH_P0;
            level_d = level_q + 2'd1;
          end
        end
      end

      DONE: begin
        if (res_ready_i) begin
          state_d = IDLE; // result taken on this edge
        end
      end

      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      level_q <= 2'd0;
      pend_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      level_q <= level_d;
      pend_q  <= pend_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/qnt_pkg.sv
`default_nettype none

package qnt_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int PIXEL_W = 16; // pixel and threshold width
  localparam int ADDR_W  = 32; // threshold entry index width

  typedef logic signed [PIXEL_W-1:0] pixel_t;    // signed pixel or threshold
  typedef logic        [ADDR_W-1:0]  thr_addr_t; // entry index into threshold memory

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  typedef enum logic {
    MODE_4BIT = 1'b0, // 4 levels, 15 thresholds
    MODE_2BIT = 1'b1  // 2 levels, 3 thresholds
  } qnt_mode_e;

  typedef enum logic [1:0] {
    IDLE     = 2'd0, // waiting for a command
    FETCH_P0 = 2'd1, // request + wait, pixel 0 threshold
    FETCH_P1 = 2'd2, // request + wait, pixel 1 threshold
    DONE     = 2'd3  // result held until taken
  } qnt_state_e;

  //////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    pixel_t    pixel0;
    pixel_t    pixel1;
    thr_addr_t base; // first entry of the pixel 0 tree
    qnt_mode_e mode;
  } qnt_cmd_t;

  typedef struct packed {
    logic      req;
    thr_addr_t addr;
  } thr_req_t;

  typedef struct packed {
    logic   gnt;    // request taken
    logic   rvalid; // rdata valid, one per grant
    pixel_t rdata;
  } thr_rsp_t;

  // 4-bit mode  {p1[3:0], p0[3:0]}
  // 2-bit mode  {4'b0, p1[1:0], p0[1:0]}
  typedef logic [7:0] qnt_result_t;

endpackage

`default_nettype wire

// File: logic/qnt_top.sv
`timescale 1ns/100ps
`default_nettype none

module qnt_top
  import qnt_pkg::*;
#(
  parameter int unsigned TREE_STRIDE = 16 // pixel 1 tree sits this far past base
) (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        cmd_valid_i,
  input  qnt_cmd_t    cmd_i,
  output logic        cmd_ready_o,

  output thr_req_t    thr_req_o,
  input  thr_rsp_t    thr_rsp_i,

  output logic        res_valid_o,
  output qnt_result_t res_o,
  input  logic        res_ready_i
);

  qnt_cmd_t   cmd_q;       // command held for the whole search
  logic       load;
  logic       fetch_pixel;
  logic       step_en;
  logic [1:0] level;
  logic [1:0] greater;
  logic       req;
  thr_addr_t  addr;

  // command captured on the accept edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_q <= '0;
    end else if (load) begin
      cmd_q <= cmd_i;
    end
  end

  assign thr_req_o = '{req: req, addr: addr};

  //////////////////////////////////////////////////
  // control + datapath
  //////////////////////////////////////////////////

  qnt_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .mode_i        (cmd_q.mode),
    .thr_gnt_i     (thr_rsp_i.gnt),
    .thr_rvalid_i  (thr_rsp_i.rvalid),
    .thr_req_o     (req),
    .res_ready_i   (res_ready_i),
    .res_valid_o   (res_valid_o),
    .load_o        (load),
    .fetch_pixel_o (fetch_pixel),
    .step_en_o     (step_en),
    .level_o       (level)
  );

  // addr_gen sees the incoming command on load to seed the roots
  qnt_addr_gen #(.TREE_STRIDE(TREE_STRIDE)) u_addr_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_i        (load),
    .cmd_i         (load ? cmd_i : cmd_q),
    .fetch_pixel_i (fetch_pixel),
    .step_en_i     (step_en),
    .level_i       (level),
    .greater_i     (greater),
    .addr_o        (addr)
  );

  qnt_cmp_acc u_cmp_acc (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_i        (load),
    .cmd_i         (cmd_q),
    .fetch_pixel_i (fetch_pixel),
    .step_en_i     (step_en),
    .rdata_i       (thr_rsp_i.rdata),
    .greater_o     (greater),
    .res_o         (res_o)
  );

endmodule

`default_nettype wire

// File: test/qnt_checker.sv
`timescale 1ns/100ps
`default_nettype none

module qnt_checker
  import qnt_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_valid_i,
  input  logic        cmd_ready_i,
  input  logic        res_valid_i,
  input  logic        res_ready_i,
  input  qnt_result_t res_i
);

  qnt_result_t exp_q [$]; // expected results in command order
  int          checked_count = 0;
  int          error_count   = 0;
  logic        busy = 1'b0;     // command taken but result not yet taken

  task automatic add_expected(input qnt_result_t value);
    exp_q.push_back(value);
  endtask

  //////////////////////////////////////////////////
  // compare at the result handshake
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (busy && cmd_ready_i) begin
        $display("cmd_ready was high at %0t while a command was still in progress", $time);
        error_count++;
      end
      if (cmd_valid_i && cmd_ready_i) busy <= 1'b1;
      if (res_valid_i && res_ready_i) begin
        busy <= 1'b0;
        if (exp_q.size() == 0) begin
          $display("a result came out at %0t with no command waiting for it", $time);
          error_count++;
        end else begin
          if (res_i !== exp_q[0]) begin
            $display("error at %0t: result 0x%02h, expected 0x%02h", $time, res_i, exp_q[0]);
            error_count++;
          end
          void'(exp_q.pop_front());
        end
        checked_count++;
      end
    end
  end

  // closing line where queued results count as missing
  task automatic report(input int assert_fails);
    error_count += exp_q.size() + assert_fails;
    $display("results checked %0d, missing %0d, assertion failures %0d, errors %0d",
             checked_count, exp_q.size(), assert_fails, error_count);
  endtask

endmodule

`default_nettype wire

// File: test/qnt_properties.sv
`timescale 1ns/100ps
`default_nettype none

module qnt_properties
  import qnt_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input thr_req_t    thr_req_o,
  input thr_rsp_t    thr_rsp_i,
  input logic        res_valid_o,
  input qnt_result_t res_o,
  input logic        res_ready_i
);

  logic outstanding;    // granted and waiting for rvalid
  int   fail_count = 0; // failed assertions, read at the end of the run

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) outstanding <= 1'b0;
    else if (thr_req_o.req && thr_rsp_i.gnt) outstanding <= 1'b1;
    else if (thr_rsp_i.rvalid) outstanding <= 1'b0;
  end

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    thr_req_o.req && !thr_rsp_i.gnt |=> thr_req_o.req && $stable(thr_req_o.addr))
    else begin
      $error("request dropped or address moved before grant");
      fail_count++;
    end

  res_held: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
    else begin
      $error("result dropped or changed before ready");
      fail_count++;
    end

  one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding |-> !thr_req_o.req)
    else begin
      $error("second request while one is outstanding");
      fail_count++;
    end

endmodule

bind qnt_top qnt_properties u_props (.*);

`default_nettype wire

// File: test/qnt_stim.txt
# T base t0..t14        : 15 ascending signed thresholds written from entry base on
# C mode p0 p1 base exp : mode 4 or 2, signed pixels, base entry, expected result in hex
T 0 -700 -600 -500 -400 -300 -200 -100 0 100 200 300 400 500 600 700
T 16 10 20 30 40 50 60 70 80 90 100 110 120 130 140 150
T 32 -1500 -1400 -1300 -1200 -1100 -1000 -900 -800 -700 -600 -500 -400 -300 -200 -100
T 48 1000 2000 3000 4000 5000 6000 7000 8000 9000 10000 11000 12000 13000 14000 15000
T 64 -7 -6 -5 -4 -3 -2 -1 0 1 2 3 4 5 6 7
C 4 0 55 0 57
C 4 -600 150 0 e1
C 4 -32768 32767 0 f0
C 4 5 -550 16 a0
C 4 -100 7500 32 7e
C 4 15001 0 48 7f
C 2 -650 25 0 09
C 2 100 -1400 16 07
C 2 -20000 -6 48 04
C 2 0 500 32 03
C 4 701 -1 0 0f
C 4 75 -1450 16 17

// File: test/qnt_tb.sv
`timescale 1ns/100ps
`default_nettype none

module qnt_tb
  import qnt_pkg::*;
;

  localparam int MAX_CMDS = 64;
  localparam int MEM_SIZE = 256;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  qnt_cmd_t    cmd;
  logic        cmd_ready;
  thr_req_t    thr_req;
  thr_rsp_t    thr_rsp;
  logic        res_valid;
  qnt_result_t res;
  logic        res_ready;

  pixel_t      mem [0:MEM_SIZE-1];   // threshold memory model
  qnt_cmd_t    cmds [0:MAX_CMDS-1];
  qnt_result_t exp_res [0:MAX_CMDS-1];
  int          n_cmd;
  logic        stim_ok;
  logic        stim_loaded;
  logic [31:0] lcg_state;

  // memory model + result sink state
  logic        mem_busy;     // granted with rvalid still owed
  logic        gnt_armed;
  int          gnt_wait;
  int          rv_wait;
  thr_addr_t   rd_addr;
  logic        rdy_armed;
  int          rdy_wait;

  qnt_top #(.TREE_STRIDE(16)) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_ready_o (cmd_ready),
    .thr_req_o   (thr_req),
    .thr_rsp_i   (thr_rsp),
    .res_valid_o (res_valid),
    .res_o       (res),
    .res_ready_i (res_ready)
  );

  qnt_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_i (cmd_ready),
    .res_valid_i (res_valid),
    .res_ready_i (res_ready),
    .res_i       (res)
  );

  always #50 clk = ~clk; // 100 ns period

  // lcg step giving a value in 0 .. span-1
  function automatic int next_rand(input int span);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[30:16]) % span;
  endfunction

  //////////////////////////////////////////////////
  // stim file
  //////////////////////////////////////////////////

  task automatic load_stim(output logic ok);
    int    fd;
    int    cnt;
    string line;
    string tag;
    int    base;
    int    m;
    int    p0;
    int    p1;
    int    ex;
    int    t [0:14];
    ok = 1'b0;
    fd = $fopen("test/qnt_stim.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        cnt  = $fgets(line, fd);
        tag  = "";
        cnt  = $sscanf(line, "%s", tag);
        if (tag == "T") begin // tree of 15 ascending thresholds
          cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", tag, base,
                        t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8], t[9], t[10],
                        t[11], t[12], t[13], t[14]);
          if (cnt != 17) ok = 1'b0; // short tree line
          for (int i = 0; i < 15; i++) begin
            mem[(base + i) % MEM_SIZE] = pixel_t'(t[i]);
          end
        end else if (tag == "C" && n_cmd < MAX_CMDS) begin
          cnt = $sscanf(line, "%s %d %d %d %d %h", tag, m, p0, p1, base, ex);
          if (cnt != 6) ok = 1'b0;
          cmds[n_cmd].pixel0 = pixel_t'(p0);
          cmds[n_cmd].pixel1 = pixel_t'(p1);
          cmds[n_cmd].base   = thr_addr_t'(base);
          cmds[n_cmd].mode   = (m == 2) ? MODE_2BIT : MODE_4BIT;
          exp_res[n_cmd]     = qnt_result_t'(ex);
          n_cmd++;
        end
      end
      $fclose(fd);
      if (n_cmd == 0) ok = 1'b0; // nothing to run
    end
  endtask

  //////////////////////////////////////////////////
  // memory model + result back-pressure
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    thr_rsp.gnt    = 1'b0;
    thr_rsp.rvalid = 1'b0;
    if (mem_busy) begin
      if (rv_wait <= 1) begin
        thr_rsp.rvalid = 1'b1;
        thr_rsp.rdata  = mem[rd_addr % MEM_SIZE];
        mem_busy       = 1'b0;
      end else begin
        rv_wait--;
      end
    end else if (thr_req.req) begin
      if (!gnt_armed) begin
        gnt_wait  = next_rand(4); // 0..3 cycles before grant
        gnt_armed = 1'b1;
      end
      if (gnt_wait == 0) begin
        thr_rsp.gnt = 1'b1;       // grant lands on the next rising edge
        rd_addr     = thr_req.addr;
        rv_wait     = 1 + next_rand(3);
        mem_busy    = 1'b1;
        gnt_armed   = 1'b0;
      end else begin
        gnt_wait--;
      end
    end

    if (res_valid) begin
      if (!rdy_armed) begin
        rdy_wait  = next_rand(4);
        rdy_armed = 1'b1;
      end
      if (rdy_wait == 0) res_ready = 1'b1;
      else rdy_wait--;
    end else begin
      res_ready = 1'b0;
      rdy_armed = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    thr_rsp     = '0;
    res_ready   = 1'b0;
    mem_busy    = 1'b0;
    gnt_armed   = 1'b0;
    gnt_wait    = 0;
    rv_wait     = 0;
    rd_addr     = '0;
    rdy_armed   = 1'b0;
    rdy_wait    = 0;
    lcg_state   = 32'hc7cc3239;
    n_cmd       = 0;
    stim_ok     = 1'b0;
    stim_loaded = 1'b0;
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem[i] = pixel_t'(16'h8000 ^ (i * 16'h0101)); // background fill
    end
    load_stim(stim_ok);

    if (!stim_ok) begin
      $display("the stimulus file test/qnt_stim.txt is missing, empty or has a malformed line");
      $display("Errors found");
      $finish;
    end else begin
      stim_loaded = 1'b1;

      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      // back-to-back commands each wait on cmd_ready
      for (int i = 0; i < n_cmd; i++) begin
        cmd_valid = 1'b1;
        cmd       = cmds[i];
        u_checker.add_expected(exp_res[i]);
        while (!cmd_ready) @(negedge clk);
        @(negedge clk); // accepted on the edge just passed
      end
      cmd_valid = 1'b0;
      cmd       = '0;

      while (u_checker.checked_count < n_cmd) @(negedge clk);
      repeat (3) @(negedge clk);
      u_checker.report(dut.u_props.fail_count);
      if (u_checker.error_count == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

  // watchdog allows 8 fetches of at most 8 cycles per command
  initial begin
    real limit_ns;
    wait (stim_loaded);
    limit_ns = (n_cmd * 8 * 8 + 20) * 100.0;
    #(limit_ns);
    $display("the run timed out after %0t with results still outstanding", $time);
    u_checker.report(dut.u_props.fail_count);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
